// ==== tests/vreadVectors.txt ====
// step line: step mask fixedReady; then one line per unit, unit 0 first
// unit: extAddr length pingPong reverse aIter aPeriod aShift aIncr bStart bIter bPeriod bShift bIncr count words
1 3 0
40 3 0 0 1 4 1 1 80 1 4 1 1 0
100 5 0 0 1 6 1 1 80 3 2 1 1 0
2 3 0
40 3 0 0 1 4 1 1 80 1 4 1 1 4 5ac0 5ac3 5ac6 5ac9
100 5 0 0 1 6 1 1 80 3 2 1 1 6 5d00 5d03 5d06 5d09 5d0c 5d0f
3 1 1
10 3 0 0 1 4 1 1 80 1 4 1 1 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 1 1
10 3 0 0 1 4 1 1 80 1 4 1 1 4 5a30 5a33 5a36 5a39
0 0 0 0 0 0 0 0 0 0 0 0 0 0
5 1 0
20 7 0 1 1 8 1 1 1 2 2 60 20 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0
6 1 0
20 7 0 1 1 8 1 1 1 2 2 60 20 4 5a60 5a6c 5a63 5a6f
0 0 0 0 0 0 0 0 0 0 0 0 0 0
7 2 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0
200 3 1 0 1 4 1 1 0 1 4 1 1 4 5d00 5d03 5d06 5d09
8 2 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0
300 3 1 0 1 4 1 1 0 1 4 1 1 4 6000 6003 6006 6009
ffffffff

// ==== list.f ====
+incdir+design
design/vreadPkg.sv
design/addressGen.sv
design/memoryWriter.sv
design/dualPortRam.sv
design/vectorRead.sv
design/databusArbiter.sv
design/vreadSystem.sv
tests/tbClock.sv
tests/tbChecker.sv
tests/vreadSystemTb.sv

// ==== Bender.yml ====
package:
  name: vread_system

sources:
  - include_dirs:
      - design
    files:
      - design/vreadPkg.sv
      - design/addressGen.sv
      - design/memoryWriter.sv
      - design/dualPortRam.sv
      - design/vectorRead.sv
      - design/databusArbiter.sv
      - design/vreadSystem.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/tbClock.sv
      - tests/tbChecker.sv
      - tests/vreadSystemTb.sv

// ==== tests/vreadSystemTb.sv ====
`timescale 1ns/1ps
`include "vread_macros.svh"

module vreadSystemTb;

   logic                     clk;
   logic                     rst;
   logic [1:0]               run = '0;
   logic [1:0]               checkMask = '0;
   vreadPkg::readCfg_t [1:0] cfg = '0;
   vreadPkg::busReq_t        extReq;
   vreadPkg::busRsp_t        extRsp = '0;
   logic [1:0]               outValid;
   logic [1:0][`DATA_W-1:0]  outData;
   logic [1:0]               done;
   int                       errors;
   int                       checks;
   int                       topErrors = 0;
   int                       timeoutCycles = 0;
   logic                     fixedReady = 1'b1;
   int                       beatIdx = 0;
   int                       ptr;
   int                       seedVal;
   logic [31:0]              vec [0:1023];

   tbClock clockGen (.clk(clk), .rst(rst));

   vreadSystem i_vreadSystem (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .cfg      (cfg),
      .extReq   (extReq),
      .extRsp   (extRsp),
      .outValid (outValid),
      .outData  (outData),
      .done     (done)
   );

   tbChecker scoreboard (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .checkMask (checkMask),
      .cfg       (cfg),
      .extReq    (extReq),
      .extRsp    (extRsp),
      .outValid  (outValid),
      .outData   (outData),
      .done      (done),
      .errors    (errors),
      .checks    (checks)
   );

   function automatic logic [`DATA_W-1:0] modelWord(input logic [`IO_ADDR_W-1:0] a);
      logic [15:0] w;
      w = a * 16'd3 + 16'h5a00;
      return {{(`DATA_W-16){1'b0}}, w};
   endfunction

   // external memory, answers 2 ns after the edge
   initial
   begin
      seedVal = $urandom(32'h474d_2d56);
      forever
      begin
         @(posedge clk);
         if (rst)
            beatIdx = 0;
         else if (extReq.valid && extRsp.ready)
            beatIdx = extRsp.last ? 0 : beatIdx + 1;
         #2;
         extRsp.ready = fixedReady ? 1'b1 : ($urandom % 4 != 0);
         extRsp.rdata = modelWord(extReq.addr + `IO_ADDR_W'(beatIdx));
         extRsp.last  = (beatIdx == extReq.len);
      end
   end

   task computeTimeout;
      int p;
      int cycles;
      int count;
      p = 0;
      cycles = 0;
      while (p < 1000 && vec[p] !== 32'hffffffff)
      begin
         p = p + 3;
         for (int u = 0; u < 2; u++)
         begin
            count  = vec[p+13];
            cycles = cycles + vec[p+1] + 1 + vec[p+9] * vec[p+10] + 10;
            p      = p + 14 + count;
         end
      end
      timeoutCycles = cycles * 4 + 200;
   endtask

   task readUnit(input int u, output logic checked);
      int count;
      cfg[u].extAddr         = vec[ptr][`IO_ADDR_W-1:0];
      cfg[u].length          = vec[ptr+1][`LEN_W-1:0];
      cfg[u].pingPong        = vec[ptr+2][0];
      cfg[u].reverse         = vec[ptr+3][0];
      cfg[u].genA.start      = '0;
      cfg[u].genA.iterations = vec[ptr+4][`MEM_ADDR_W-1:0];
      cfg[u].genA.period     = vec[ptr+5][`PERIOD_W-1:0];
      cfg[u].genA.shift      = vec[ptr+6][`MEM_ADDR_W-1:0];
      cfg[u].genA.incr       = vec[ptr+7][`MEM_ADDR_W-1:0];
      cfg[u].genB.start      = vec[ptr+8][`MEM_ADDR_W-1:0];
      cfg[u].genB.iterations = vec[ptr+9][`MEM_ADDR_W-1:0];
      cfg[u].genB.period     = vec[ptr+10][`PERIOD_W-1:0];
      cfg[u].genB.shift      = vec[ptr+11][`MEM_ADDR_W-1:0];
      cfg[u].genB.incr       = vec[ptr+12][`MEM_ADDR_W-1:0];
      count = vec[ptr+13];
      ptr   = ptr + 14;
      for (int k = 0; k < count; k++)
         scoreboard.pushExpected(u, vec[ptr+k][`DATA_W-1:0]);
      ptr     = ptr + count;
      checked = (count > 0);
   endtask

   task runStep;
      logic [1:0] mask;
      logic       check0;
      logic       check1;
      mask       = vec[ptr+1][1:0];
      fixedReady = vec[ptr+2][0];
      ptr        = ptr + 3;
      readUnit(0, check0);
      readUnit(1, check1);
      @(posedge clk);
      #2;
      checkMask = {check1, check0};
      run       = mask;
      @(posedge clk);
      #2;
      run = '0;
      wait ((done & mask) == mask);
      repeat (2) @(posedge clk);
   endtask

   initial
   begin
      $readmemh("tests/vreadVectors.txt", vec);
      if (vec[0] === 32'hx)
      begin
         $display("vector file tests/vreadVectors.txt could not be read");
         topErrors++;
      end
      else
         computeTimeout();
      wait (rst == 1'b0);
      @(posedge clk);
      ptr = 0;
      while (topErrors == 0 && ptr < 1000 && vec[ptr] !== 32'hffffffff)
         runStep();
      repeat (4) @(posedge clk);
      $display("checks %0d, errors %0d", checks, errors + topErrors);
      if (errors + topErrors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   // watchdog
   initial
   begin
      wait (timeoutCycles > 0);
      repeat (timeoutCycles) @(posedge clk);
      $display("timeout, the tests did not finish in %0d cycles", timeoutCycles);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== tests/tbChecker.sv ====
`timescale 1ns/1ps
`include "vread_macros.svh"

module tbChecker
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic [1:0]                    run,
   input  logic [1:0]                    checkMask,
   input  vreadPkg::readCfg_t [1:0]      cfg,
   input  vreadPkg::busReq_t             extReq,
   input  vreadPkg::busRsp_t             extRsp,
   input  logic [1:0]                    outValid,
   input  logic [1:0][`DATA_W-1:0]       outData,
   input  logic [1:0]                    done,
   output int                            errors,
   output int                            checks
);

   logic [`DATA_W-1:0]    expQ0 [$];
   logic [`DATA_W-1:0]    expQ1 [$];
   int                    errCount = 0;
   int                    checkCount = 0;
   logic [1:0]            armed = '0;
   logic [1:0]            checking = '0;
   logic [1:0]            justRan = '0;
   logic [1:0]            lastDone = '0;
   logic                  resetSeen = 1'b0;
   logic                  bothStarted = 1'b0;
   logic                  inBurst = 1'b0;
   logic [`IO_ADDR_W-1:0] burstAddr;
   logic [`LEN_W-1:0]     burstLen;
   int                    beatCnt;
   int                    owner;
   int                    outCnt [2];
   int                    expOut [2];
   logic [`IO_ADDR_W-1:0] unitAddr [2];

   assign errors = errCount;
   assign checks = checkCount;

   task pushExpected(input int unit, input logic [`DATA_W-1:0] word);
      if (unit == 0)
         expQ0.push_back(word);
      else
         expQ1.push_back(word);
   endtask

   task reportError(input string msg);
      errCount++;
      $display("FAILED at %0t ns: %s", $time, msg);
   endtask

   task compareWord(input int unit, input logic [`DATA_W-1:0] word);
      logic [`DATA_W-1:0] expWord;
      int                 left;
      left = (unit == 0) ? expQ0.size() : expQ1.size();
      checkCount++;
      if (left == 0)
         reportError($sformatf("unit %0d gave extra word %h", unit, word));
      else
      begin
         expWord = (unit == 0) ? expQ0.pop_front() : expQ1.pop_front();
         if (word !== expWord)
            reportError($sformatf("unit %0d read %h, expected %h", unit, word, expWord));
      end
   endtask

   always @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         armed     = '0;
         justRan   = '0;
         inBurst   = 1'b0;
         resetSeen = 1'b1;
      end
      else
      begin
         if (resetSeen)
         begin
            checkCount++;
            if (done !== 2'b11)
               reportError("done not high after reset");
            resetSeen = 1'b0;
         end
         // bus rules
         if (extReq.valid)
         begin
            if (!inBurst)
            begin
               inBurst   = 1'b1;
               burstAddr = extReq.addr;
               burstLen  = extReq.len;
               beatCnt   = 0;
               owner     = (armed[0] && !lastDone[0] && extReq.addr == unitAddr[0]) ? 0 : 1;
               if (bothStarted)
               begin
                  checkCount++;
                  if (owner != 0)
                     reportError("unit 1 served before unit 0");
                  bothStarted = 1'b0;
               end
            end
            else if (extReq.addr !== burstAddr || extReq.len !== burstLen)
               reportError("bus addr or len changed inside a burst");
            if (extRsp.ready)
            begin
               beatCnt++;
               if (extRsp.last)
               begin
                  checkCount++;
                  if (beatCnt != cfg[owner].length + 1)
                     reportError($sformatf("burst ended after %0d beats", beatCnt));
                  inBurst         = 1'b0;
                  lastDone[owner] = 1'b1;
               end
               else if (beatCnt > cfg[owner].length)
                  reportError("burst ran past its length");
            end
         end
         else if (inBurst)
         begin
            reportError("bus valid dropped inside a burst");
            inBurst = 1'b0;
         end
         for (int u = 0; u < 2; u++)
         begin
            if (outValid[u])
            begin
               outCnt[u]++;
               if (checking[u])
                  compareWord(u, outData[u]);
            end
            if (justRan[u])
            begin
               checkCount++;
               if (done[u] !== 1'b0)
                  reportError($sformatf("unit %0d done high the cycle after run", u));
               justRan[u] = 1'b0;
            end
            else if (armed[u] && done[u])
            begin
               checkCount++;
               if (outCnt[u] != expOut[u] || !lastDone[u])
                  reportError($sformatf("unit %0d done early, %0d of %0d words",
                                        u, outCnt[u], expOut[u]));
               if (checking[u] && ((u == 0) ? expQ0.size() : expQ1.size()) != 0)
                  reportError($sformatf("unit %0d missed expected words", u));
               armed[u] = 1'b0;
            end
            if (run[u])
            begin
               armed[u]    = 1'b1;
               justRan[u]  = 1'b1;
               checking[u] = checkMask[u];
               lastDone[u] = 1'b0;
               outCnt[u]   = 0;
               expOut[u]   = cfg[u].genB.iterations * cfg[u].genB.period;
               unitAddr[u] = cfg[u].extAddr;
            end
         end
         if (run == 2'b11)
            bothStarted = 1'b1;
      end
   end

endmodule

// ==== tests/tbClock.sv ====
`timescale 1ns/1ps

module tbClock
(
   output logic clk,
   output logic rst
);

   // 40 ns period
   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial
   begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      #2 rst = 1'b0;
   end

endmodule

// ==== design/vreadSystem.sv ====
`timescale 1ns/1ps
`include "vread_macros.svh"

module vreadSystem
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic [1:0]                    run,
   input  vreadPkg::readCfg_t [1:0]      cfg,
   output vreadPkg::busReq_t             extReq,
   input  vreadPkg::busRsp_t             extRsp,
   output logic [1:0]                    outValid,
   output logic [1:0][`DATA_W-1:0]       outData,
   output logic [1:0]                    done
);

   vreadPkg::busReq_t [1:0] unitReq;
   vreadPkg::busRsp_t [1:0] unitRsp;

   vectorRead unit0 (
      .clk      (clk),
      .rst      (rst),
      .run      (run[0]),
      .cfg      (cfg[0]),
      .busReq   (unitReq[0]),
      .busRsp   (unitRsp[0]),
      .outValid (outValid[0]),
      .outData  (outData[0]),
      .done     (done[0])
   );

   vectorRead unit1 (
      .clk      (clk),
      .rst      (rst),
      .run      (run[1]),
      .cfg      (cfg[1]),
      .busReq   (unitReq[1]),
      .busRsp   (unitRsp[1]),
      .outValid (outValid[1]),
      .outData  (outData[1]),
      .done     (done[1])
   );

   // one burst at a time on the shared bus
   databusArbiter arbiter (
      .clk     (clk),
      .rst     (rst),
      .unitReq (unitReq),
      .unitRsp (unitRsp),
      .extReq  (extReq),
      .extRsp  (extRsp)
   );

endmodule

// ==== design/databusArbiter.sv ====
`timescale 1ns/1ps

module databusArbiter
(
   input  logic                    clk,
   input  logic                    rst,
   input  vreadPkg::busReq_t [1:0] unitReq,
   output vreadPkg::busRsp_t [1:0] unitRsp,
   output vreadPkg::busReq_t       extReq,
   input  vreadPkg::busRsp_t       extRsp
);

   logic locked;
   logic grantReg;
   logic lastServed;
   logic pick;
   logic sel;
   logic lastTaken;

   // the unit not served most recently goes first
   always_comb
   begin
      pick = !lastServed;
      if (!unitReq[!lastServed].valid && unitReq[lastServed].valid)
         pick = lastServed;
   end

   assign sel       = locked ? grantReg : pick;
   assign extReq    = unitReq[sel];
   assign lastTaken = extReq.valid & extRsp.ready & extRsp.last;

   // other unit sees no ready and no last
   always_comb
   begin
      for (int i = 0; i < 2; i++)
      begin
         unitRsp[i]       = extRsp;
         unitRsp[i].ready = extRsp.ready && (sel == 1'(i));
         unitRsp[i].last  = extRsp.last && (sel == 1'(i));
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         locked     <= 1'b0;
         grantReg   <= 1'b0;
         lastServed <= 1'b1;
      end
      else
      begin
         // lock from first valid so addr and len hold for the burst
         if (!locked && extReq.valid)
         begin
            locked   <= 1'b1;
            grantReg <= sel;
         end
         if (lastTaken)
         begin
            locked     <= 1'b0;
            lastServed <= sel;
         end
      end
   end

endmodule

// ==== design/vectorRead.sv ====
`timescale 1ns/1ps
`include "vread_macros.svh"

module vectorRead
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 run,
   input  vreadPkg::readCfg_t   cfg,
   output vreadPkg::busReq_t    busReq,
   input  vreadPkg::busRsp_t    busRsp,
   output logic                 outValid,
   output logic [`DATA_W-1:0]   outData,
   output logic                 done
);

   logic                   pingPongState;
   logic                   nextState;
   logic                   reverseReg;
   logic                   reqValid;
   logic                   doneA;
   logic                   doneB;
   logic                   beatTaken;
   logic [`IO_ADDR_W-1:0]  extAddrReg;
   logic [`LEN_W-1:0]      lenReg;
   vreadPkg::addrGenCfg_t  cfgA;
   vreadPkg::addrGenCfg_t  cfgB;
   logic                   genAValid;
   logic                   genAReady;
   logic [`MEM_ADDR_W-1:0] genAAddr;
   logic                   genBValid;
   logic [`MEM_ADDR_W-1:0] genBAddr;
   logic                   genBDone;
   logic [`MEM_ADDR_W-1:0] rdAddr;
   vreadPkg::memWrite_t    wr;

   function automatic logic [`MEM_ADDR_W-1:0] reverseBits(input logic [`MEM_ADDR_W-1:0] word);
      logic [`MEM_ADDR_W-1:0] res;
      for (int i = 0; i < `MEM_ADDR_W; i++)
         res[i] = word[`MEM_ADDR_W-1-i];
      return res;
   endfunction

   assign nextState = cfg.pingPong & ~pingPongState;
   assign beatTaken = reqValid & busRsp.ready;
   assign done      = doneA & doneB;
   assign rdAddr    = reverseReg ? reverseBits(genBAddr) : genBAddr;

   // writer fills one half, reader drains the other
   always_comb
   begin
      cfgA = cfg.genA;
      cfgA.start = '0;
      cfgA.start[`MEM_ADDR_W-1] = ~nextState;
      cfgB = cfg.genB;
      if (cfg.pingPong)
         cfgB.start[`MEM_ADDR_W-1] = nextState;
   end

   always_comb
   begin
      busReq.valid = reqValid;
      busReq.addr  = extAddrReg;
      busReq.len   = lenReg;
   end

   always_ff @(posedge clk)
   begin
      if (run)
      begin
         extAddrReg <= cfg.extAddr;
         lenReg     <= cfg.length;
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         pingPongState <= 1'b0;
         reverseReg    <= 1'b0;
         reqValid      <= 1'b0;
         doneA         <= 1'b1;
         doneB         <= 1'b1;
         outValid      <= 1'b0;
      end
      else
      begin
         outValid <= genBValid;
         if (run)
         begin
            pingPongState <= nextState;
            reverseReg    <= cfg.reverse;
            reqValid      <= 1'b1;
            doneA         <= 1'b0;
            doneB         <= 1'b0;
         end
         else
         begin
            // burst ends on the accepted last beat
            if (beatTaken && busRsp.last)
            begin
               reqValid <= 1'b0;
               doneA    <= 1'b1;
            end
            if (genBDone)
               doneB <= 1'b1;
         end
      end
   end

   addressGen genA (
      .clk   (clk),
      .rst   (rst),
      .run   (run),
      .cfg   (cfgA),
      .valid (genAValid),
      .ready (genAReady),
      .addr  (genAAddr),
      .done  ()
   );

   // read side never stalls
   addressGen genB (
      .clk   (clk),
      .rst   (rst),
      .run   (run),
      .cfg   (cfgB),
      .valid (genBValid),
      .ready (1'b1),
      .addr  (genBAddr),
      .done  (genBDone)
   );

   memoryWriter writer (
      .clk       (clk),
      .rst       (rst),
      .genValid  (genAValid),
      .genReady  (genAReady),
      .genAddr   (genAAddr),
      .beat      (busRsp),
      .beatTaken (beatTaken),
      .wr        (wr)
   );

   dualPortRam #(
      .ADDR_W (`MEM_ADDR_W),
      .DATA_W (`DATA_W)
   ) buffer (
      .clk    (clk),
      .wr     (wr),
      .rdEn   (genBValid),
      .rdAddr (rdAddr),
      .rdData (outData)
   );

endmodule

// ==== design/dualPortRam.sv ====
`timescale 1ns/1ps
`include "vread_macros.svh"

module dualPortRam
#(
   parameter int ADDR_W = `MEM_ADDR_W,
   parameter int DATA_W = `DATA_W
)
(
   input  logic                clk,
   input  vreadPkg::memWrite_t wr,
   input  logic                rdEn,
   input  logic [ADDR_W-1:0]   rdAddr,
   output logic [DATA_W-1:0]   rdData
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk)
   begin
      if (wr.en)
         mem[wr.addr[ADDR_W-1:0]] <= wr.data[DATA_W-1:0];
      // registered read
      if (rdEn)
         rdData <= mem[rdAddr];
   end

endmodule

// ==== design/memoryWriter.sv ====
`timescale 1ns/1ps
`include "vread_macros.svh"

module memoryWriter
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   genValid,
   output logic                   genReady,
   input  logic [`MEM_ADDR_W-1:0] genAddr,
   input  vreadPkg::busRsp_t      beat,
   input  logic                   beatTaken,
   output vreadPkg::memWrite_t    wr
);

   logic                   wrEn;
   logic [`MEM_ADDR_W-1:0] wrAddr;
   logic [`DATA_W-1:0]     wrData;

   // one address consumed per accepted beat
   assign genReady = beatTaken;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         wrEn <= 1'b0;
      else
         wrEn <= beatTaken & genValid;
   end

   always_ff @(posedge clk)
   begin
      if (beatTaken)
      begin
         wrAddr <= genAddr;
         wrData <= beat.rdata;
      end
   end

   // write lands one cycle after its beat
   always_comb
   begin
      wr.en   = wrEn;
      wr.addr = wrAddr;
      wr.data = wrData;
   end

endmodule

// ==== design/addressGen.sv ====
`timescale 1ns/1ps
`include "vread_macros.svh"

module addressGen
(
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   run,
   input  vreadPkg::addrGenCfg_t  cfg,
   output logic                   valid,
   input  logic                   ready,
   output logic [`MEM_ADDR_W-1:0] addr,
   output logic                   done
);

   logic                   active;
   logic [`PERIOD_W-1:0]   perCnt;
   logic [`MEM_ADDR_W-1:0] iterCnt;
   logic [`PERIOD_W-1:0]   periodReg;
   logic [`MEM_ADDR_W-1:0] iterReg;
   logic [`MEM_ADDR_W-1:0] shiftReg;
   logic [`MEM_ADDR_W-1:0] incrReg;
   logic                   step;
   logic                   periodEnd;
   logic                   lastAddr;

   assign valid     = active;
   assign step      = active & ready;
   assign periodEnd = (perCnt == periodReg - 1'b1);
   assign lastAddr  = periodEnd && (iterCnt == iterReg - 1'b1);

   // program, latched on run
   always_ff @(posedge clk)
   begin
      if (run)
      begin
         periodReg <= cfg.period;
         iterReg   <= cfg.iterations;
         shiftReg  <= cfg.shift;
         incrReg   <= cfg.incr;
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         active  <= 1'b0;
         done    <= 1'b1;
         perCnt  <= '0;
         iterCnt <= '0;
         addr    <= '0;
      end
      else if (run)
      begin
         // empty program finishes at once
         active  <= (cfg.iterations != '0) && (cfg.period != '0);
         done    <= (cfg.iterations == '0) || (cfg.period == '0);
         perCnt  <= '0;
         iterCnt <= '0;
         addr    <= cfg.start;
      end
      else if (step)
      begin
         if (periodEnd)
         begin
            perCnt  <= '0;
            iterCnt <= iterCnt + 1'b1;
            addr    <= addr + shiftReg;
         end
         else
         begin
            perCnt <= perCnt + 1'b1;
            addr   <= addr + incrReg;
         end
         if (lastAddr)
         begin
            active <= 1'b0;
            done   <= 1'b1;
         end
      end
   end

endmodule

// ==== design/vreadPkg.sv ====
`include "vread_macros.svh"

package vreadPkg;

   // request toward the external bus
   typedef struct packed {
      logic                  valid;
      logic [`IO_ADDR_W-1:0] addr;
      logic [`LEN_W-1:0]     len;
   } busReq_t;

   // answer from the external bus, one beat per ready
   typedef struct packed {
      logic               ready;
      logic [`DATA_W-1:0] rdata;
      logic               last;
   } busRsp_t;

   typedef struct packed {
      logic [`MEM_ADDR_W-1:0] start;
      logic [`MEM_ADDR_W-1:0] iterations;
      logic [`PERIOD_W-1:0]   period;
      logic [`MEM_ADDR_W-1:0] shift;
      logic [`MEM_ADDR_W-1:0] incr;
   } addrGenCfg_t;

   // genA.start is derived inside the unit
   typedef struct packed {
      logic [`IO_ADDR_W-1:0] extAddr;
      logic [`LEN_W-1:0]     length;
      logic                  pingPong;
      logic                  reverse;
      addrGenCfg_t           genA;
      addrGenCfg_t           genB;
   } readCfg_t;

   typedef struct packed {
      logic                   en;
      logic [`MEM_ADDR_W-1:0] addr;
      logic [`DATA_W-1:0]     data;
   } memWrite_t;

endpackage

// ==== design/vread_macros.svh ====
`ifndef VREAD_MACROS_SVH
`define VREAD_MACROS_SVH

// data word on the bus and in the buffers
`define DATA_W 32

// buffer address, top bit picks the ping-pong half
`define MEM_ADDR_W 8

// external word address
`define IO_ADDR_W 16

// burst length, beats minus one
`define LEN_W 8

// period counter
`define PERIOD_W 6

`endif
